/* verilog/dnc_write_pkg.sv */
package dnc_write_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data path width
  localparam int WORD_BITS = 32;

  // Counters and row indices
  localparam int IDX_BITS = 16;

  // Output group selector
  localparam int SEL_BITS = 3;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [IDX_BITS-1:0]  idx_t;
  typedef logic [SEL_BITS-1:0]  out_sel_t;

  ////////////////////////////////////////
  // Row groups, in stream order
  ////////////////////////////////////////

  // W rows each for key, erase and vector
  localparam out_sel_t SEL_KEY    = 3'd0;
  localparam out_sel_t SEL_BETA   = 3'd1;
  localparam out_sel_t SEL_ERASE  = 3'd2;
  localparam out_sel_t SEL_VECTOR = 3'd3;
  localparam out_sel_t SEL_GA     = 3'd4;
  // Last row of a run
  localparam out_sel_t SEL_GW     = 3'd5;

endpackage

/* verilog/dnc_term_if.sv */
`timescale 1ns/10ps

interface dnc_term_if;

  // One weight/hidden pair per valid cycle
  logic                     valid;
  dnc_write_pkg::word_t     weight;
  dnc_write_pkg::word_t     hidden;

  // Row boundaries
  logic                     first;
  logic                     last;

  // Row tag
  dnc_write_pkg::out_sel_t  sel;
  dnc_write_pkg::idx_t      k;

  // Modulus latched at START
  dnc_write_pkg::word_t     modulo;

  modport source (output valid, weight, hidden, first, last, sel, k, modulo);
  modport sink   (input  valid, weight, hidden, first, last, sel, k, modulo);

endinterface

/* verilog/dnc_row_if.sv */
`timescale 1ns/10ps

interface dnc_row_if;

  // One finished row per valid cycle
  logic                     valid;
  dnc_write_pkg::word_t     value;

  // Which output and which element
  dnc_write_pkg::out_sel_t  sel;
  dnc_write_pkg::idx_t      k;

  // Set on the write gate row
  logic                     final_row;

  modport source (output valid, value, sel, k, final_row);
  modport sink   (input  valid, value, sel, k, final_row);

endinterface

/* verilog/dnc_write_sequencer.sv */
`timescale 1ns/10ps

module dnc_write_sequencer #(
  parameter int MAX_L = 16
) (
  input  logic                  CLK,
  input  logic                  RST,

  input  logic                  START,
  input  logic                  H_IN_ENABLE,
  input  logic                  U_IN_ENABLE,

  input  dnc_write_pkg::word_t  SIZE_W_IN,
  input  dnc_write_pkg::word_t  SIZE_L_IN,
  input  dnc_write_pkg::word_t  MODULO_IN,
  input  dnc_write_pkg::word_t  H_IN,
  input  dnc_write_pkg::word_t  U_IN,

  dnc_term_if.source            term,
  output logic                  busy
);

  localparam int ADDR_BITS = $clog2(MAX_L);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    LOAD_HIDDEN,
    STREAM_WEIGHTS
  } state_t;

  state_t state;

  // Sizes and modulus for this run
  dnc_write_pkg::idx_t   size_w;
  dnc_write_pkg::idx_t   size_l;
  dnc_write_pkg::word_t  modulo;

  // l within a row, k within a group
  dnc_write_pkg::idx_t   l_cnt;
  dnc_write_pkg::idx_t   k_cnt;
  dnc_write_pkg::out_sel_t sel;

  // Hidden state buffer
  dnc_write_pkg::word_t  h_mem [MAX_L];

  logic l_end;
  logic k_end;
  logic vec_group;

  ////////////////////////////////////////
  // Row position decode
  ////////////////////////////////////////

  assign l_end = (l_cnt == size_l - 16'd1);
  assign k_end = (k_cnt == size_w - 16'd1);

  // Groups that span W rows
  assign vec_group = (sel == dnc_write_pkg::SEL_KEY) ||
                     (sel == dnc_write_pkg::SEL_ERASE) ||
                     (sel == dnc_write_pkg::SEL_VECTOR);

  assign busy        = (state != IDLE);
  assign term.modulo = modulo;

  // Hidden vector store
  always_ff @(posedge CLK) begin
    if (state == LOAD_HIDDEN && H_IN_ENABLE) begin
      h_mem[l_cnt[ADDR_BITS-1:0]] <= H_IN;
    end
  end

  // Term payload, aligned with term.valid
  always_ff @(posedge CLK) begin
    if (state == STREAM_WEIGHTS && U_IN_ENABLE) begin
      term.weight <= U_IN;
      term.hidden <= h_mem[l_cnt[ADDR_BITS-1:0]];
    end
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE;
      size_w     <= '0;
      size_l     <= '0;
      modulo     <= '0;
      l_cnt      <= '0;
      k_cnt      <= '0;
      sel        <= dnc_write_pkg::SEL_KEY;
      term.valid <= 1'b0;
      term.first <= 1'b0;
      term.last  <= 1'b0;
      term.sel   <= dnc_write_pkg::SEL_KEY;
      term.k     <= '0;
    end else begin
      // Single-cycle term strobe
      term.valid <= 1'b0;
      case (state)
        IDLE: begin
          // Strobes here are dropped
          if (START) begin
            size_w <= SIZE_W_IN[dnc_write_pkg::IDX_BITS-1:0];
            size_l <= SIZE_L_IN[dnc_write_pkg::IDX_BITS-1:0];
            modulo <= MODULO_IN;
            l_cnt  <= '0;
            k_cnt  <= '0;
            sel    <= dnc_write_pkg::SEL_KEY;
            state  <= LOAD_HIDDEN;
          end
        end
        LOAD_HIDDEN: begin
          if (H_IN_ENABLE) begin
            if (l_end) begin
              l_cnt <= '0;
              state <= STREAM_WEIGHTS;
            end else begin
              l_cnt <= l_cnt + 16'd1;
            end
          end
        end
        STREAM_WEIGHTS: begin
          if (U_IN_ENABLE) begin
            term.valid <= 1'b1;
            term.first <= (l_cnt == '0);
            term.last  <= l_end;
            term.sel   <= sel;
            term.k     <= k_cnt;
            if (!l_end) begin
              l_cnt <= l_cnt + 16'd1;
            end else begin
              l_cnt <= '0;
              // Next row: next k, or next group
              if (vec_group && !k_end) begin
                k_cnt <= k_cnt + 16'd1;
              end else begin
                k_cnt <= '0;
                sel   <= sel + 3'd1;
              end
              // Write gate closes the run
              if (sel == dnc_write_pkg::SEL_GW) begin
                state <= IDLE;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* verilog/dnc_mac_stage.sv */
`timescale 1ns/10ps

module dnc_mac_stage (
  input  logic         CLK,
  input  logic         RST,

  dnc_term_if.sink     term,
  dnc_row_if.source    row
);

  // Full product and one carry bit for the running sum
  typedef logic [2*dnc_write_pkg::WORD_BITS-1:0] prod_t;
  typedef logic [dnc_write_pkg::WORD_BITS:0]     sum_t;

  prod_t                 product;
  prod_t                 product_red;
  dnc_write_pkg::word_t  term_red;
  dnc_write_pkg::word_t  acc;
  dnc_write_pkg::word_t  acc_base;
  dnc_write_pkg::word_t  acc_next;
  sum_t                  sum;
  sum_t                  sum_red;

  ////////////////////////////////////////
  // Modular multiply-accumulate
  ////////////////////////////////////////

  always_comb begin
    product     = prod_t'(term.weight) * prod_t'(term.hidden);
    product_red = product % prod_t'(term.modulo);
    term_red    = product_red[dnc_write_pkg::WORD_BITS-1:0];
    // First term of a row starts from zero
    acc_base    = term.first ? '0 : acc;
    sum         = sum_t'(acc_base) + sum_t'(term_red);
    // Both addends below modulus, one subtract is enough
    sum_red     = (sum >= sum_t'(term.modulo)) ? sum - sum_t'(term.modulo) : sum;
    acc_next    = sum_red[dnc_write_pkg::WORD_BITS-1:0];
  end

  // Accumulator and row payload
  always_ff @(posedge CLK) begin
    if (term.valid) begin
      acc <= acc_next;
      if (term.last) begin
        row.value <= acc_next;
        row.sel   <= term.sel;
        row.k     <= term.k;
      end
    end
  end

  // Row strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row.valid     <= 1'b0;
      row.final_row <= 1'b0;
    end else begin
      row.valid     <= term.valid && term.last;
      row.final_row <= term.valid && term.last &&
                       (term.sel == dnc_write_pkg::SEL_GW);
    end
  end

endmodule

/* verilog/dnc_write_router.sv */
`timescale 1ns/10ps

module dnc_write_router (
  input  logic                  CLK,
  input  logic                  RST,

  dnc_row_if.sink               row,

  output logic                  READY,

  output logic                  K_OUT_ENABLE,
  output logic                  E_OUT_ENABLE,
  output logic                  V_OUT_ENABLE,
  output logic                  BETA_OUT_ENABLE,
  output logic                  GA_OUT_ENABLE,
  output logic                  GW_OUT_ENABLE,

  output dnc_write_pkg::word_t  K_OUT,
  output dnc_write_pkg::word_t  E_OUT,
  output dnc_write_pkg::word_t  V_OUT,
  output dnc_write_pkg::word_t  BETA_OUT,
  output dnc_write_pkg::word_t  GA_OUT,
  output dnc_write_pkg::word_t  GW_OUT,
  output dnc_write_pkg::idx_t   K_OUT_INDEX
);

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY           <= 1'b0;
      K_OUT_ENABLE    <= 1'b0;
      E_OUT_ENABLE    <= 1'b0;
      V_OUT_ENABLE    <= 1'b0;
      BETA_OUT_ENABLE <= 1'b0;
      GA_OUT_ENABLE   <= 1'b0;
      GW_OUT_ENABLE   <= 1'b0;
      K_OUT           <= '0;
      E_OUT           <= '0;
      V_OUT           <= '0;
      BETA_OUT        <= '0;
      GA_OUT          <= '0;
      GW_OUT          <= '0;
      K_OUT_INDEX     <= '0;
    end else begin
      // Enables are one-cycle pulses
      K_OUT_ENABLE    <= 1'b0;
      E_OUT_ENABLE    <= 1'b0;
      V_OUT_ENABLE    <= 1'b0;
      BETA_OUT_ENABLE <= 1'b0;
      GA_OUT_ENABLE   <= 1'b0;
      GW_OUT_ENABLE   <= 1'b0;
      // Done together with the write gate
      READY           <= row.valid && row.final_row;
      if (row.valid) begin
        case (row.sel)
          dnc_write_pkg::SEL_KEY: begin
            K_OUT        <= row.value;
            K_OUT_INDEX  <= row.k;
            K_OUT_ENABLE <= 1'b1;
          end
          dnc_write_pkg::SEL_BETA: begin
            BETA_OUT        <= row.value;
            BETA_OUT_ENABLE <= 1'b1;
          end
          dnc_write_pkg::SEL_ERASE: begin
            E_OUT        <= row.value;
            K_OUT_INDEX  <= row.k;
            E_OUT_ENABLE <= 1'b1;
          end
          dnc_write_pkg::SEL_VECTOR: begin
            V_OUT        <= row.value;
            K_OUT_INDEX  <= row.k;
            V_OUT_ENABLE <= 1'b1;
          end
          dnc_write_pkg::SEL_GA: begin
            GA_OUT        <= row.value;
            GA_OUT_ENABLE <= 1'b1;
          end
          dnc_write_pkg::SEL_GW: begin
            GW_OUT        <= row.value;
            GW_OUT_ENABLE <= 1'b1;
          end
          // Unused codes drop the row
          default: ;
        endcase
      end
    end
  end

endmodule

/* verilog/dnc_write_interface_vector.sv */
`timescale 1ns/10ps

module dnc_write_interface_vector #(
  parameter int MAX_L = 16
) (
  input  logic                  CLK,
  input  logic                  RST,

  // Control
  input  logic                  START,
  output logic                  READY,
  output logic                  BUSY,

  // Input strobes
  input  logic                  H_IN_ENABLE,
  input  logic                  U_IN_ENABLE,

  // Sizes, modulus, hidden state and weights
  input  dnc_write_pkg::word_t  SIZE_W_IN,
  input  dnc_write_pkg::word_t  SIZE_L_IN,
  input  dnc_write_pkg::word_t  MODULO_IN,
  input  dnc_write_pkg::word_t  H_IN,
  input  dnc_write_pkg::word_t  U_IN,

  // Output strobes
  output logic                  K_OUT_ENABLE,
  output logic                  E_OUT_ENABLE,
  output logic                  V_OUT_ENABLE,
  output logic                  BETA_OUT_ENABLE,
  output logic                  GA_OUT_ENABLE,
  output logic                  GW_OUT_ENABLE,

  // Results
  output dnc_write_pkg::word_t  K_OUT,
  output dnc_write_pkg::word_t  E_OUT,
  output dnc_write_pkg::word_t  V_OUT,
  output dnc_write_pkg::word_t  BETA_OUT,
  output dnc_write_pkg::word_t  GA_OUT,
  output dnc_write_pkg::word_t  GW_OUT,
  output dnc_write_pkg::idx_t   K_OUT_INDEX
);

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////

  dnc_term_if term_bus ();
  dnc_row_if  row_bus ();

  // Weight stream to terms
  dnc_write_sequencer #(
    .MAX_L (MAX_L)
  ) u_sequencer (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .H_IN_ENABLE (H_IN_ENABLE),
    .U_IN_ENABLE (U_IN_ENABLE),
    .SIZE_W_IN   (SIZE_W_IN),
    .SIZE_L_IN   (SIZE_L_IN),
    .MODULO_IN   (MODULO_IN),
    .H_IN        (H_IN),
    .U_IN        (U_IN),
    .term        (term_bus.source),
    .busy        (BUSY)
  );

  // Terms to row sums
  dnc_mac_stage u_mac (
    .CLK  (CLK),
    .RST  (RST),
    .term (term_bus.sink),
    .row  (row_bus.source)
  );

  // Row sums to output ports
  dnc_write_router u_router (
    .CLK             (CLK),
    .RST             (RST),
    .row             (row_bus.sink),
    .READY           (READY),
    .K_OUT_ENABLE    (K_OUT_ENABLE),
    .E_OUT_ENABLE    (E_OUT_ENABLE),
    .V_OUT_ENABLE    (V_OUT_ENABLE),
    .BETA_OUT_ENABLE (BETA_OUT_ENABLE),
    .GA_OUT_ENABLE   (GA_OUT_ENABLE),
    .GW_OUT_ENABLE   (GW_OUT_ENABLE),
    .K_OUT           (K_OUT),
    .E_OUT           (E_OUT),
    .V_OUT           (V_OUT),
    .BETA_OUT        (BETA_OUT),
    .GA_OUT          (GA_OUT),
    .GW_OUT          (GW_OUT),
    .K_OUT_INDEX     (K_OUT_INDEX)
  );

endmodule

/* bench/dnc_write_tb.sv */
`timescale 1ns/10ps

module dnc_write_tb;

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic                  H_IN_ENABLE;
  logic                  U_IN_ENABLE;
  dnc_write_pkg::word_t  SIZE_W_IN;
  dnc_write_pkg::word_t  SIZE_L_IN;
  dnc_write_pkg::word_t  MODULO_IN;
  dnc_write_pkg::word_t  H_IN;
  dnc_write_pkg::word_t  U_IN;
  logic                  READY;
  logic                  BUSY;
  logic                  K_OUT_ENABLE;
  logic                  E_OUT_ENABLE;
  logic                  V_OUT_ENABLE;
  logic                  BETA_OUT_ENABLE;
  logic                  GA_OUT_ENABLE;
  logic                  GW_OUT_ENABLE;
  dnc_write_pkg::word_t  K_OUT;
  dnc_write_pkg::word_t  E_OUT;
  dnc_write_pkg::word_t  V_OUT;
  dnc_write_pkg::word_t  BETA_OUT;
  dnc_write_pkg::word_t  GA_OUT;
  dnc_write_pkg::word_t  GW_OUT;
  dnc_write_pkg::idx_t   K_OUT_INDEX;

  // All numbers of the stimulus file, in file order
  logic [31:0] tok [$];
  int          case_start [$];
  int          wd_limit = 0;
  bit          load_ok = 0;

  // Rows in flight, oldest first
  int          exp_sel [$];
  logic [31:0] exp_val [$];
  int          exp_k [$];
  int          exp_cyc [$];

  int          cyc = 0;
  int          err_count = 0;
  int          test_count = 0;
  int          test_fails = 0;
  bit          ready_seen = 0;

  dnc_write_interface_vector #(
    .MAX_L (16)
  ) UUT (
    .CLK (CLK), .RST (RST), .START (START), .READY (READY), .BUSY (BUSY),
    .H_IN_ENABLE (H_IN_ENABLE), .U_IN_ENABLE (U_IN_ENABLE),
    .SIZE_W_IN (SIZE_W_IN), .SIZE_L_IN (SIZE_L_IN), .MODULO_IN (MODULO_IN),
    .H_IN (H_IN), .U_IN (U_IN),
    .K_OUT_ENABLE (K_OUT_ENABLE), .E_OUT_ENABLE (E_OUT_ENABLE),
    .V_OUT_ENABLE (V_OUT_ENABLE), .BETA_OUT_ENABLE (BETA_OUT_ENABLE),
    .GA_OUT_ENABLE (GA_OUT_ENABLE), .GW_OUT_ENABLE (GW_OUT_ENABLE),
    .K_OUT (K_OUT), .E_OUT (E_OUT), .V_OUT (V_OUT), .BETA_OUT (BETA_OUT),
    .GA_OUT (GA_OUT), .GW_OUT (GW_OUT), .K_OUT_INDEX (K_OUT_INDEX)
  );

  // 20 ns clock
  always #10 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h got %h", name, exp, act);
      err_count++;
    end
  endtask

  function automatic string row_name(input int sel);
    case (sel)
      0: return "K_OUT";
      1: return "BETA_OUT";
      2: return "E_OUT";
      3: return "V_OUT";
      4: return "GA_OUT";
      default: return "GW_OUT";
    endcase
  endfunction

  function automatic int hex_value(input byte c);
    if (c >= "0" && c <= "9") return int'(c) - 48;
    if (c >= "a" && c <= "f") return int'(c) - 87;
    if (c >= "A" && c <= "F") return int'(c) - 55;
    return -1;
  endfunction

  // Hex tokens of one line, up to a # comment
  task automatic split_line(input string line);
    int          d;
    bit          have;
    logic [31:0] val;
    have = 0;
    val  = '0;
    for (int i = 0; i < line.len(); i++) begin
      if (line[i] == "#") break;
      d = hex_value(line[i]);
      if (d >= 0) begin
        val  = (val << 4) | 32'(d);
        have = 1;
      end else if (have) begin
        tok.push_back(val);
        val  = '0;
        have = 0;
      end
    end
    if (have) tok.push_back(val);
  endtask

  // Reads all cases and sizes the watchdog
  task automatic load_stimulus();
    int    fd;
    int    pos;
    int    w;
    int    l;
    int    rows;
    string line;
    fd = $fopen("bench/dnc_write_stimulus.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) > 0) split_line(line);
    $fclose(fd);
    pos = 0;
    load_ok = 1;
    while (pos < tok.size()) begin
      w    = int'(tok[pos]);
      l    = int'(tok[pos+1]);
      rows = 3 * w + 3;
      case_start.push_back(pos);
      pos += 4 + l + rows * l + rows;
      wd_limit += (rows * l + l) * 3 + 50;
    end
    if (pos != tok.size() || case_start.size() == 0) load_ok = 0;
  endtask

  // Row order: W keys, beta, W erase, W vector, ga, gw
  task automatic expect_row(input int r, input int w, input logic [31:0] val, input int due);
    int sel;
    int k;
    k = 0;
    if (r < w) begin
      sel = 0;
      k   = r;
    end else if (r == w) sel = 1;
    else if (r < 2 * w + 1) begin
      sel = 2;
      k   = r - w - 1;
    end else if (r < 3 * w + 1) begin
      sel = 3;
      k   = r - 2 * w - 1;
    end else if (r == 3 * w + 1) sel = 4;
    else sel = 5;
    exp_sel.push_back(sel);
    exp_val.push_back(val);
    exp_k.push_back(k);
    exp_cyc.push_back(due);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    if (err_count != errs_before) test_fails++;
    $display("test %0d %s: %s", test_count, name,
             (err_count == errs_before) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  always @(posedge CLK) begin
    int          n_en;
    int          sel;
    logic [31:0] val;
    cyc  = cyc + 1;
    n_en = int'(K_OUT_ENABLE) + int'(BETA_OUT_ENABLE) + int'(E_OUT_ENABLE) +
           int'(V_OUT_ENABLE) + int'(GA_OUT_ENABLE) + int'(GW_OUT_ENABLE);
    sel  = 0;
    val  = K_OUT;
    if (BETA_OUT_ENABLE) begin
      sel = 1;
      val = BETA_OUT;
    end else if (E_OUT_ENABLE) begin
      sel = 2;
      val = E_OUT;
    end else if (V_OUT_ENABLE) begin
      sel = 3;
      val = V_OUT;
    end else if (GA_OUT_ENABLE) begin
      sel = 4;
      val = GA_OUT;
    end else if (GW_OUT_ENABLE) begin
      sel = 5;
      val = GW_OUT;
    end
    if (n_en > 1) begin
      $display("more than one output enable in cycle %0d", cyc);
      err_count++;
    end else if (n_en == 1 && exp_sel.size() == 0) begin
      $display("extra %s enable in cycle %0d with no row pending", row_name(sel), cyc);
      err_count++;
    end else if (n_en == 1) begin
      if (exp_sel[0] != sel) begin
        $display("got %s enable where %s was due", row_name(sel), row_name(exp_sel[0]));
        err_count++;
      end else begin
        check(row_name(sel), exp_val[0], val);
        if (sel == 0 || sel == 2 || sel == 3)
          check("K_OUT_INDEX", 32'(exp_k[0]), 32'(K_OUT_INDEX));
      end
      // Enable should be exactly on time
      if (exp_cyc[0] != cyc) begin
        $display("%s enable in cycle %0d, due in cycle %0d", row_name(sel), cyc, exp_cyc[0]);
        err_count++;
      end
      void'(exp_sel.pop_front());
      void'(exp_val.pop_front());
      void'(exp_k.pop_front());
      void'(exp_cyc.pop_front());
    end
    if (READY) begin
      ready_seen = 1;
      if (!GW_OUT_ENABLE) begin
        $display("READY raised in cycle %0d without the write gate", cyc);
        err_count++;
      end
    end else if (GW_OUT_ENABLE) begin
      $display("write gate in cycle %0d came without READY", cyc);
      err_count++;
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_test();
    int e0;
    e0 = err_count;
    check("READY", 32'd0, 32'(READY));
    check("BUSY", 32'd0, 32'(BUSY));
    check("K_OUT_ENABLE", 32'd0, 32'(K_OUT_ENABLE));
    check("E_OUT_ENABLE", 32'd0, 32'(E_OUT_ENABLE));
    check("V_OUT_ENABLE", 32'd0, 32'(V_OUT_ENABLE));
    check("BETA_OUT_ENABLE", 32'd0, 32'(BETA_OUT_ENABLE));
    check("GA_OUT_ENABLE", 32'd0, 32'(GA_OUT_ENABLE));
    check("GW_OUT_ENABLE", 32'd0, 32'(GW_OUT_ENABLE));
    check("K_OUT", 32'd0, K_OUT);
    check("E_OUT", 32'd0, E_OUT);
    check("V_OUT", 32'd0, V_OUT);
    check("BETA_OUT", 32'd0, BETA_OUT);
    check("GA_OUT", 32'd0, GA_OUT);
    check("GW_OUT", 32'd0, GW_OUT);
    check("K_OUT_INDEX", 32'd0, 32'(K_OUT_INDEX));
    end_test("reset values", e0);
  endtask

  task automatic run_case(input int c);
    int base;
    int w;
    int l;
    int rows;
    int up;
    int ep;
    int n;
    int e0;
    bit gap;
    e0   = err_count;
    base = case_start[c];
    w    = int'(tok[base]);
    l    = int'(tok[base+1]);
    gap  = tok[base+3] != 0;
    rows = 3 * w + 3;
    up   = base + 4 + l;
    ep   = up + rows * l;
    SIZE_W_IN = tok[base];
    SIZE_L_IN = tok[base+1];
    MODULO_IN = tok[base+2];
    START     = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    check("BUSY", 32'd1, 32'(BUSY));
    // Hidden vector
    for (int j = 0; j < l; j++) begin
      H_IN        = tok[base+4+j];
      H_IN_ENABLE = 1'b1;
      @(negedge CLK);
      H_IN_ENABLE = 1'b0;
      if (gap) @(negedge CLK);
    end
    ready_seen = 0;
    // Weights, row by row
    for (int r = 0; r < rows; r++) begin
      for (int j = 0; j < l; j++) begin
        U_IN        = tok[up+r*l+j];
        U_IN_ENABLE = 1'b1;
        // START while busy, with a bogus size
        if (r == 1 && j == 0) begin
          START     = 1'b1;
          SIZE_W_IN = 32'd7;
        end
        // Sampled next edge, enable registered three edges on
        if (j == l - 1) expect_row(r, w, tok[ep+r], cyc + 4);
        @(negedge CLK);
        U_IN_ENABLE = 1'b0;
        START       = 1'b0;
        SIZE_W_IN   = tok[base];
        if (gap) @(negedge CLK);
      end
    end
    n = 0;
    while ((exp_sel.size() != 0 || !ready_seen) && n < 40) begin
      @(negedge CLK);
      n++;
    end
    if (exp_sel.size() != 0) begin
      $display("%0d row outputs never arrived in case %0d", exp_sel.size(), c + 1);
      err_count++;
      exp_sel.delete();
      exp_val.delete();
      exp_k.delete();
      exp_cyc.delete();
    end
    if (!ready_seen) begin
      $display("READY never raised in case %0d", c + 1);
      err_count++;
    end
    end_test($sformatf("case %0d run W=%0d L=%0d", c + 1, w, l), e0);
  endtask

  // Stray strobes while idle must not disturb anything
  task automatic idle_test(input int c);
    int e0;
    int base;
    int w;
    int l;
    int ep;
    e0   = err_count;
    base = case_start[c];
    w    = int'(tok[base]);
    l    = int'(tok[base+1]);
    // Expected results of the run just finished
    ep   = base + 4 + l + (3 * w + 3) * l;
    check("BUSY", 32'd0, 32'(BUSY));
    H_IN        = 32'h5A5A_0001;
    U_IN        = 32'hA5A5_0002;
    H_IN_ENABLE = 1'b1;
    U_IN_ENABLE = 1'b1;
    @(negedge CLK);
    H_IN_ENABLE = 1'b0;
    @(negedge CLK);
    U_IN_ENABLE = 1'b0;
    repeat (6) @(negedge CLK);
    // Ports keep the last result of each group
    check("K_OUT", tok[ep+w-1], K_OUT);
    check("BETA_OUT", tok[ep+w], BETA_OUT);
    check("E_OUT", tok[ep+2*w], E_OUT);
    check("V_OUT", tok[ep+3*w], V_OUT);
    check("GA_OUT", tok[ep+3*w+1], GA_OUT);
    check("GW_OUT", tok[ep+3*w+2], GW_OUT);
    // Last vector row leaves its k behind
    check("K_OUT_INDEX", 32'(w - 1), 32'(K_OUT_INDEX));
    check("BUSY", 32'd0, 32'(BUSY));
    end_test($sformatf("case %0d idle strobes", c + 1), e0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    H_IN_ENABLE = 1'b0;
    U_IN_ENABLE = 1'b0;
    SIZE_W_IN   = '0;
    SIZE_L_IN   = '0;
    MODULO_IN   = '0;
    H_IN        = '0;
    U_IN        = '0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    load_stimulus();
    if (!load_ok) begin
      $display("could not read a complete case from the stimulus file");
      $display("SOME TESTS FAILED");
    end else begin
      reset_test();
      for (int c = 0; c < case_start.size(); c++) begin
        run_case(c);
        idle_test(c);
      end
      $display("%0d tests run, %0d failed, %0d errors", test_count, test_fails, err_count);
      if (err_count == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
    end
    $finish;
  end

  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge CLK);
    $display("watchdog ran out after %0d cycles", wd_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* bench/dnc_write_stimulus.txt */
# Per case: W L MODULUS GAP, then L hidden values, (3W+3)*L weights row by row,
# then 3W+3 expected results in row order (key, beta, erase, vector, ga, gw). All hex.

# W=2 L=3, gapped strobes
2 3 3E8 1
3 5 7
1 2 3  2 0 1  4 1 0
0 3 2  1 1 1  5 0 0
0 0 6  2 2 2  3 1 4
22 D 11 1D F F 2A 1E 2A

# Modulus 7, wrap in products and sums, back to back strobes
1 2 7 0
5 6
3 4  6 6  2 5  4 3  1 1  FFFFFFFF 2
4 3 5 3 4 6

# W=4 L=5, back to back strobes
4 5 3E8 0
A 14 1E 28 32
0 1 0 0 1  1 1 0 0 1  2 1 0 0 1  3 1 0 0 1  4 1 0 0 1
5 1 0 0 1  6 1 0 0 1  7 1 0 0 1  8 1 0 0 1  9 1 0 0 1
A 1 0 0 1  B 1 0 0 1  C 1 0 0 1  D 1 0 0 1  E 1 0 0 1
46 50 5A 64 6E 78 82 8C 96 A0 AA B4 BE C8 D2

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = dnc_write_tb
FILELIST = vlog.f

OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* vlog.f */
verilog/dnc_write_pkg.sv
verilog/dnc_term_if.sv
verilog/dnc_row_if.sv
verilog/dnc_write_sequencer.sv
verilog/dnc_mac_stage.sv
verilog/dnc_write_router.sv
verilog/dnc_write_interface_vector.sv
bench/dnc_write_tb.sv
